// ==== include/dcache_config.svh ====
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// Geometry of the cache and the processor port
`define DC_ADDR_W       32
`define DC_CACHE_BYTES  256
`define DC_LINE_BYTES   16

// Derived counts and field widths
`define DC_LINE_WORDS   (`DC_LINE_BYTES / 4)
`define DC_LINES        (`DC_CACHE_BYTES / `DC_LINE_BYTES)
`define DC_INDEX_W      $clog2(`DC_LINES)
`define DC_OFFSET_W     $clog2(`DC_LINE_WORDS)
`define DC_TAG_W        (`DC_ADDR_W - `DC_INDEX_W - `DC_OFFSET_W - 2)

// Wishbone cycle type identifiers
`define DC_CTI_BURST    3'b010
`define DC_CTI_EOB      3'b111

`endif

// ==== src/dcache_pkg.sv ====
`default_nettype none

`include "dcache_config.svh"

package dcache_pkg;

        typedef enum logic [2:0] {
                CTI_BURST = `DC_CTI_BURST,      // Incrementing burst
                CTI_EOB   = `DC_CTI_EOB         // Last beat or single access
        } cti_t;

        // Word 0 sits in the low 32 bits
        typedef logic [`DC_LINE_WORDS-1:0][31:0] line_t;

        typedef struct packed {
                logic                   valid;
                logic                   dirty;
                logic [`DC_TAG_W-1:0]   tag;
        } tag_entry_t;

        typedef struct packed {
                logic                   we;
                logic [`DC_ADDR_W-1:0]  addr;
                logic [31:0]            wdata;
                logic [3:0]             ben;
        } cpu_req_t;

        typedef struct packed {
                logic                           en;
                logic [`DC_INDEX_W-1:0]         index;
                line_t                          line;
                logic [`DC_LINE_BYTES-1:0]      mask;   // One bit per byte
                tag_entry_t                     tag;
        } store_wr_t;

        typedef enum logic [1:0] {
                LINE_READ,
                LINE_WRITE,
                SINGLE_READ,
                SINGLE_WRITE
        } xfer_kind_t;

        typedef struct packed {
                xfer_kind_t             kind;
                logic [`DC_ADDR_W-1:0]  addr;   // Line base for bursts
                line_t                  line;   // Write-back payload
                logic [31:0]            data;
                logic [3:0]             sel;
        } xfer_req_t;

        typedef struct packed {
                logic                   cyc;
                logic                   stb;
                logic                   we;
                logic [`DC_ADDR_W-1:0]  adr;
                logic [31:0]            dat;
                logic [3:0]             sel;
                cti_t                   cti;
        } wb_out_t;

endpackage

`default_nettype wire

// ==== src/dcache_store.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dcache_config.svh"

module dcache_store
(
        input  logic                            i_clk,
        input  logic                            i_reset,
        input  logic [`DC_INDEX_W-1:0]          i_rd_index,
        output dcache_pkg::tag_entry_t          o_rd_tag,
        output dcache_pkg::line_t               o_rd_line,
        input  dcache_pkg::store_wr_t           i_wr
);

// ----------------------------------------
// Arrays
// ----------------------------------------

dcache_pkg::tag_entry_t tags  [`DC_LINES];
dcache_pkg::line_t      lines [`DC_LINES];

// Combinational read port
always_comb
begin
        o_rd_tag  = tags[i_rd_index];
        o_rd_line = lines[i_rd_index];
end

// Tag array, only valid bits are cleared
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                for (int i = 0; i < `DC_LINES; i++)
                        tags[i].valid <= 1'b0;
        end
        else if (i_wr.en)
        begin
                tags[i_wr.index] <= i_wr.tag;
        end
end

// Line data with per byte mask
always_ff @(posedge i_clk)
begin
        if (i_wr.en)
        begin
                for (int b = 0; b < `DC_LINE_BYTES; b++)
                begin
                        if (i_wr.mask[b])
                                lines[i_wr.index][b / 4][(b % 4) * 8 +: 8] <=
                                        i_wr.line[b / 4][(b % 4) * 8 +: 8];
                end
        end
end

// ----------------------------------------
// Checks
// ----------------------------------------

// A controller write must touch at least one byte
a_wr_mask: assert property (@(posedge i_clk) disable iff (i_reset)
        i_wr.en |-> (i_wr.mask != '0));

endmodule

`default_nettype wire

// ==== src/wb_burst_master.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dcache_config.svh"

module wb_burst_master
(
        input  logic                            i_clk,
        input  logic                            i_reset,
        input  logic                            i_start,
        input  dcache_pkg::xfer_req_t           i_xfer,
        output logic                            o_done,
        output dcache_pkg::line_t               o_line,
        output logic [31:0]                     o_word,
        output dcache_pkg::wb_out_t             o_wb,
        input  logic                            i_wb_ack,
        input  logic [31:0]                     i_wb_dat
);

localparam int OFF_W = `DC_OFFSET_W;
localparam logic [OFF_W-1:0] LAST_BEAT = OFF_W'(`DC_LINE_WORDS - 1);

dcache_pkg::wb_out_t    wb_q;
dcache_pkg::line_t      buf_q;          // Write-back source or fetched words
logic [OFF_W-1:0]       beat_q;
logic [OFF_W-1:0]       beat_nxt;
logic                   done_q;
logic                   beat_ok;
logic                   is_line;
logic                   is_write;

always_comb
begin
        beat_ok  = wb_q.cyc && wb_q.stb && i_wb_ack;
        beat_nxt = beat_q + 1'b1;
        is_line  = (i_xfer.kind == dcache_pkg::LINE_READ) ||
                   (i_xfer.kind == dcache_pkg::LINE_WRITE);
        is_write = (i_xfer.kind == dcache_pkg::LINE_WRITE) ||
                   (i_xfer.kind == dcache_pkg::SINGLE_WRITE);
end

// ----------------------------------------
// Bus sequencing
// ----------------------------------------

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                wb_q     <= '0;
                wb_q.cti <= dcache_pkg::CTI_EOB;
                beat_q   <= '0;
                done_q   <= 1'b0;
        end
        else
        begin
                done_q <= 1'b0;

                if (i_start)
                begin
                        wb_q.cyc <= 1'b1;
                        wb_q.stb <= 1'b1;
                        wb_q.we  <= is_write;
                        wb_q.adr <= i_xfer.addr;
                        wb_q.sel <= is_line ? 4'hf : i_xfer.sel;
                        wb_q.dat <= (i_xfer.kind == dcache_pkg::LINE_WRITE) ?
                                    i_xfer.line[0] : i_xfer.data;
                        wb_q.cti <= is_line ? dcache_pkg::CTI_BURST : dcache_pkg::CTI_EOB;
                        beat_q   <= '0;
                end
                else if (beat_ok)
                begin
                        if (wb_q.cti == dcache_pkg::CTI_EOB)
                        begin
                                wb_q.cyc <= 1'b0;       // Transfer over
                                wb_q.stb <= 1'b0;
                                wb_q.we  <= 1'b0;
                                done_q   <= 1'b1;
                        end
                        else
                        begin
                                beat_q   <= beat_nxt;
                                wb_q.adr <= wb_q.adr + 32'd4;
                                wb_q.dat <= buf_q[beat_nxt];
                                wb_q.cti <= (beat_nxt == LAST_BEAT) ?
                                            dcache_pkg::CTI_EOB : dcache_pkg::CTI_BURST;
                        end
                end
        end
end

// Line buffer
always_ff @(posedge i_clk)
begin
        if (i_start)
                buf_q <= i_xfer.line;
        else if (beat_ok && !wb_q.we)
                buf_q[beat_q] <= i_wb_dat;      // Single reads land in word 0
end

always_comb
begin
        o_wb   = wb_q;
        o_done = done_q;
        o_line = buf_q;
        o_word = buf_q[0];
end

// ----------------------------------------
// Checks
// ----------------------------------------

// Slave acks only inside a strobed cycle
a_ack_in_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
        i_wb_ack |-> (wb_q.cyc && wb_q.stb));

// Controller must wait for done before the next transfer
a_no_overlap: assert property (@(posedge i_clk) disable iff (i_reset)
        i_start |-> !wb_q.cyc);

endmodule

`default_nettype wire

// ==== src/dcache_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dcache_config.svh"

module dcache_ctrl
(
        input  logic                            i_clk,
        input  logic                            i_reset,
        input  logic                            i_rd,
        input  logic                            i_wr,
        input  dcache_pkg::cpu_req_t            i_req,
        input  logic                            i_cache_en,
        output logic                            o_ack,
        output logic [31:0]                     o_rdata,
        output logic [`DC_INDEX_W-1:0]          o_rd_index,
        input  dcache_pkg::tag_entry_t          i_rd_tag,
        input  dcache_pkg::line_t               i_rd_line,
        output dcache_pkg::store_wr_t           o_store_wr,
        output logic                            o_xfer_start,
        output dcache_pkg::xfer_req_t           o_xfer_req,
        input  logic                            i_xfer_done,
        input  dcache_pkg::line_t               i_xfer_line,
        input  logic [31:0]                     i_xfer_word
);

localparam int OFF_W   = `DC_OFFSET_W;
localparam int IDX_W   = `DC_INDEX_W;
localparam int TAG_W   = `DC_TAG_W;
localparam int LB      = `DC_LINE_BYTES;
localparam int IDX_LSB = OFF_W + 2;
localparam int TAG_LSB = IDX_LSB + IDX_W;

typedef enum logic [1:0] { IDLE, WRITEBACK, FILL, UNCACHED } state_t;

state_t                 state_q, state_d;
dcache_pkg::cpu_req_t   req_q;          // Held across a miss
dcache_pkg::cpu_req_t   cur;            // Request being worked on
dcache_pkg::line_t      fill_line;
logic [OFF_W-1:0]       word;
logic                   access;
logic                   hit;

// ----------------------------------------
// Helpers
// ----------------------------------------

// Store data merged into a fetched line
function automatic dcache_pkg::line_t merge_word(input dcache_pkg::line_t line,
                                                 input dcache_pkg::cpu_req_t req);
        dcache_pkg::line_t      merged;
        logic [OFF_W-1:0]       w;
        merged = line;
        w      = req.addr[2 +: OFF_W];
        if (req.we)
        begin
                for (int b = 0; b < 4; b++)
                begin
                        if (req.ben[b])
                                merged[w][b * 8 +: 8] = req.wdata[b * 8 +: 8];
                end
        end
        return merged;
endfunction

function automatic dcache_pkg::xfer_req_t fill_req(input logic [`DC_ADDR_W-1:0] addr);
        dcache_pkg::xfer_req_t  r;
        r      = '0;
        r.kind = dcache_pkg::LINE_READ;
        r.addr = {addr[`DC_ADDR_W-1:IDX_LSB], {IDX_LSB{1'b0}}};
        return r;
endfunction

// Live request in IDLE, held request otherwise
always_comb
begin
        cur = req_q;
        if (state_q == IDLE)
        begin
                cur    = i_req;
                cur.we = i_wr;
        end
end

always_comb
begin
        o_rd_index = cur.addr[IDX_LSB +: IDX_W];
        word       = cur.addr[2 +: OFF_W];
        access     = i_rd || i_wr;
        hit        = i_rd_tag.valid && (i_rd_tag.tag == cur.addr[TAG_LSB +: TAG_W]);
        fill_line  = merge_word(i_xfer_line, cur);
end

// ----------------------------------------
// State machine
// ----------------------------------------

always_comb
begin
        state_d      = state_q;
        o_ack        = 1'b0;
        o_rdata      = i_rd_line[word];
        o_store_wr   = '0;
        o_xfer_start = 1'b0;
        o_xfer_req   = '0;

        case (state_q)
        IDLE:
        begin
                if (access && !i_cache_en)
                begin
                        o_xfer_start    = 1'b1;
                        o_xfer_req.kind = cur.we ? dcache_pkg::SINGLE_WRITE :
                                                   dcache_pkg::SINGLE_READ;
                        o_xfer_req.addr = cur.addr;
                        o_xfer_req.data = cur.wdata;
                        o_xfer_req.sel  = cur.ben;
                        state_d         = UNCACHED;
                end
                else if (access && hit)
                begin
                        o_ack = 1'b1;
                        if (cur.we)
                        begin
                                o_store_wr.en        = 1'b1;
                                o_store_wr.index     = o_rd_index;
                                o_store_wr.line      = {`DC_LINE_WORDS{cur.wdata}};
                                o_store_wr.mask      = LB'(cur.ben) << (4 * word);
                                o_store_wr.tag       = i_rd_tag;
                                o_store_wr.tag.dirty = 1'b1;
                        end
                end
                else if (access && i_rd_tag.valid && i_rd_tag.dirty)
                begin
                        // Victim base rebuilt from its tag
                        o_xfer_start    = 1'b1;
                        o_xfer_req.kind = dcache_pkg::LINE_WRITE;
                        o_xfer_req.addr = {i_rd_tag.tag, o_rd_index, {IDX_LSB{1'b0}}};
                        o_xfer_req.line = i_rd_line;
                        state_d         = WRITEBACK;
                end
                else if (access)
                begin
                        o_xfer_start = 1'b1;
                        o_xfer_req   = fill_req(cur.addr);
                        state_d      = FILL;
                end
        end

        WRITEBACK:
        begin
                if (i_xfer_done)
                begin
                        o_xfer_start = 1'b1;
                        o_xfer_req   = fill_req(cur.addr);
                        state_d      = FILL;
                end
        end

        FILL:
        begin
                if (i_xfer_done)
                begin
                        o_store_wr.en        = 1'b1;
                        o_store_wr.index     = o_rd_index;
                        o_store_wr.line      = fill_line;
                        o_store_wr.mask      = '1;
                        o_store_wr.tag.valid = 1'b1;
                        o_store_wr.tag.dirty = cur.we;  // Clean for a read miss
                        o_store_wr.tag.tag   = cur.addr[TAG_LSB +: TAG_W];
                        o_ack                = 1'b1;
                        o_rdata              = fill_line[word];
                        state_d              = IDLE;
                end
        end

        UNCACHED:
        begin
                o_rdata = i_xfer_word;
                if (i_xfer_done)
                begin
                        o_ack   = 1'b1;
                        state_d = IDLE;
                end
        end

        default:
                state_d = IDLE;
        endcase
end

always_ff @(posedge i_clk)
begin
        if (i_reset)
                state_q <= IDLE;
        else
                state_q <= state_d;
end

always_ff @(posedge i_clk)
begin
        if (state_q == IDLE)
                req_q <= cur;   // Last one seen in IDLE is the missing one
end

// Done only answers a transfer that this FSM started
a_done_busy: assert property (@(posedge i_clk) disable iff (i_reset)
        i_xfer_done |-> (state_q != IDLE));

endmodule

`default_nettype wire

// ==== src/dcache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dcache_config.svh"

module dcache_top
(
        input  logic                            i_clk,
        input  logic                            i_reset,
        input  logic                            i_rd,
        input  logic                            i_wr,
        input  dcache_pkg::cpu_req_t            i_req,
        input  logic                            i_cache_en,
        output logic                            o_ack,
        output logic [31:0]                     o_rdata,
        output dcache_pkg::wb_out_t             o_wb,
        input  logic                            i_wb_ack,
        input  logic [31:0]                     i_wb_dat
);

// ----------------------------------------
// Internal connections
// ----------------------------------------

logic [`DC_INDEX_W-1:0]         rd_index;
dcache_pkg::tag_entry_t         rd_tag;
dcache_pkg::line_t              rd_line;
dcache_pkg::store_wr_t          store_wr;
logic                           xfer_start;
dcache_pkg::xfer_req_t          xfer_req;
logic                           xfer_done;
dcache_pkg::line_t              xfer_line;
logic [31:0]                    xfer_word;

dcache_store u_store
(
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_rd_index     (rd_index),
        .o_rd_tag       (rd_tag),
        .o_rd_line      (rd_line),
        .i_wr           (store_wr)
);

dcache_ctrl u_ctrl
(
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_rd           (i_rd),
        .i_wr           (i_wr),
        .i_req          (i_req),
        .i_cache_en     (i_cache_en),
        .o_ack          (o_ack),
        .o_rdata        (o_rdata),
        .o_rd_index     (rd_index),
        .i_rd_tag       (rd_tag),
        .i_rd_line      (rd_line),
        .o_store_wr     (store_wr),
        .o_xfer_start   (xfer_start),
        .o_xfer_req     (xfer_req),
        .i_xfer_done    (xfer_done),
        .i_xfer_line    (xfer_line),
        .i_xfer_word    (xfer_word)
);

wb_burst_master u_master
(
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_start        (xfer_start),
        .i_xfer         (xfer_req),
        .o_done         (xfer_done),
        .o_line         (xfer_line),
        .o_word         (xfer_word),
        .o_wb           (o_wb),
        .i_wb_ack       (i_wb_ack),
        .i_wb_dat       (i_wb_dat)
);

endmodule

`default_nettype wire

// ==== testbench/wb_mem_model.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dcache_config.svh"

module wb_mem_model
#(
        parameter int LOG_N = 64
)
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  dcache_pkg::wb_out_t     i_wb,
        output logic                    o_ack,
        output logic [31:0]             o_dat,
        output int                      o_log_n,
        output dcache_pkg::wb_out_t     o_log [LOG_N]
);

// ----------------------------------------
// Storage, 1 KB of words
// ----------------------------------------

logic [31:0]    mem [256];
int             seed = 15;
int             wait_q;         // Cycles left before the next ack

initial
begin
        for (int i = 0; i < 256; i++)
                mem[i] = {16'hA5C3, 6'd0, 10'(i * 4)};  // Word holds its own address
end

always @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_ack   <= 1'b0;
                o_dat   <= '0;
                o_log_n <= 0;
                wait_q  <= 0;
        end
        else if (i_wb.cyc && i_wb.stb && o_ack)
        begin
                // Beat completes on this edge
                o_ack <= 1'b0;
                if (i_wb.we)
                begin
                        for (int b = 0; b < 4; b++)
                        begin
                                if (i_wb.sel[b])
                                        mem[i_wb.adr[9:2]][b * 8 +: 8] <= i_wb.dat[b * 8 +: 8];
                        end
                end
                if (o_log_n < LOG_N)
                        o_log[o_log_n] <= i_wb;
                o_log_n <= o_log_n + 1;
                wait_q  <= $random(seed) & 3;   // 0 to 3 idle cycles
        end
        else if (i_wb.cyc && i_wb.stb)
        begin
                if (wait_q == 0)
                begin
                        o_ack <= 1'b1;
                        o_dat <= mem[i_wb.adr[9:2]];
                end
                else
                        wait_q <= wait_q - 1;
        end
end

endmodule

`default_nettype wire

// ==== testbench/tb_dcache.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dcache_config.svh"

module tb_dcache;

localparam int LOG_N   = 64;
localparam int TIMEOUT = 200;

typedef struct packed {
        logic           wr;
        logic           cache_en;
        logic [31:0]    addr;
        logic [31:0]    data;
        logic [3:0]     ben;
        logic [31:0]    exp_rdata;
        logic [31:0]    victim;         // Base of the dirty line written back
        logic [3:0]     exp_rd;
        logic [3:0]     exp_wr;
} entry_t;

logic                   i_clk;
logic                   i_reset;
logic                   i_rd;
logic                   i_wr;
dcache_pkg::cpu_req_t   i_req;
logic                   i_cache_en;
logic                   o_ack;
logic [31:0]            o_rdata;
dcache_pkg::wb_out_t    wb;
logic                   wb_ack;
logic [31:0]            wb_dat;
int                     log_n;
dcache_pkg::wb_out_t    beat_log [LOG_N];

entry_t                 steps [$];
string                  names [$];
logic [31:0]            shadow [256];   // Memory as the processor should see it

dcache_top uut
(
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_rd           (i_rd),
        .i_wr           (i_wr),
        .i_req          (i_req),
        .i_cache_en     (i_cache_en),
        .o_ack          (o_ack),
        .o_rdata        (o_rdata),
        .o_wb           (wb),
        .i_wb_ack       (wb_ack),
        .i_wb_dat       (wb_dat)
);

wb_mem_model #(.LOG_N(LOG_N)) mem
(
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_wb           (wb),
        .o_ack          (wb_ack),
        .o_dat          (wb_dat),
        .o_log_n        (log_n),
        .o_log          (beat_log)
);

initial
begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
end

// ----------------------------------------
// Checks
// ----------------------------------------

task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped");
endtask

task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
                abort_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
endtask

task automatic check_count(input string name, input int exp, input int act);
        if (exp != act)
                abort_run($sformatf("Error: %s expected %0d actual %0d", name, exp, act));
endtask

task automatic check_cti(input string name, input dcache_pkg::cti_t exp,
                         input dcache_pkg::cti_t act);
        if (exp !== act)
                abort_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
endtask

// One logged beat against the access that caused it
task automatic check_beat(input string name, input dcache_pkg::wb_out_t beat,
                          input entry_t e, input int idx);
        logic [31:0]            base;
        logic [31:0]            adr;
        logic [3:0]             sel;
        dcache_pkg::cti_t       cti;
        base = beat.we ? e.victim : (e.addr & ~32'(`DC_LINE_BYTES - 1));
        cti  = (idx == `DC_LINE_WORDS - 1) ? dcache_pkg::CTI_EOB : dcache_pkg::CTI_BURST;
        sel  = 4'hf;    // Bursts move whole words
        if (!e.cache_en)
        begin
                base = e.addr;
                cti  = dcache_pkg::CTI_EOB;
                sel  = e.ben;
        end
        adr = base + 32'(idx * 4);
        check_word({name, " adr"}, adr, beat.adr);
        check_word({name, " sel"}, 32'(sel), 32'(beat.sel));
        check_cti({name, " cti"}, cti, beat.cti);
        if (beat.we)
                check_word({name, " dat"}, e.cache_en ? shadow[adr[9:2]] : e.data,
                           beat.dat);
endtask

// ----------------------------------------
// Stimulus
// ----------------------------------------

task automatic add_entry(input string name, input logic wr, input logic en,
                         input logic [31:0] addr, input logic [31:0] data,
                         input logic [3:0] ben, input logic [31:0] exp,
                         input int rd_n, input int wr_n, input logic [31:0] victim);
        entry_t e;
        e = '{wr, en, addr, data, ben, exp, victim, 4'(rd_n), 4'(wr_n)};
        steps.push_back(e);
        names.push_back(name);
endtask

task automatic run_entry(input int n);
        entry_t                 e;
        string                  name;
        int                     first;
        int                     cycles;
        int                     rd_cnt;
        int                     wr_cnt;
        int                     k;
        logic [31:0]            rdata;
        e    = steps[n];
        name = names[n];
        @(negedge i_clk);
        i_rd         = !e.wr;
        i_wr         = e.wr;
        i_req.we     = e.wr;
        i_req.addr   = e.addr;
        i_req.wdata  = e.data;
        i_req.ben    = e.ben;
        i_cache_en   = e.cache_en;
        first        = log_n;
        cycles       = 0;
        do
        begin
                @(negedge i_clk);
                cycles++;
                if (cycles > TIMEOUT)
                        abort_run($sformatf("Timeout: %s got no acknowledge", name));
        end
        while (!o_ack);
        rdata = o_rdata;
        i_rd  = 1'b0;
        i_wr  = 1'b0;
        if (log_n > LOG_N)
                abort_run("Bus beat log overflowed");
        rd_cnt = 0;
        wr_cnt = 0;
        for (k = first; k < log_n; k++)
        begin
                if (beat_log[k].we)
                begin
                        check_beat(name, beat_log[k], e, wr_cnt);
                        wr_cnt++;
                end
                else
                begin
                        check_beat(name, beat_log[k], e, rd_cnt);
                        rd_cnt++;
                end
        end
        check_count({name, " read beats"}, int'(e.exp_rd), rd_cnt);
        check_count({name, " write beats"}, int'(e.exp_wr), wr_cnt);
        if (!e.wr)
        begin
                check_word({name, " shadow"}, e.exp_rdata, shadow[e.addr[9:2]]);
                check_word({name, " rdata"}, e.exp_rdata, rdata);
        end
        // Shadow follows every store, cached or not
        for (k = 0; k < 4; k++)
        begin
                if (e.wr && e.ben[k])
                        shadow[e.addr[9:2]][k * 8 +: 8] = e.data[k * 8 +: 8];
        end
endtask

initial
begin
        i_reset    = 1'b1;
        i_rd       = 1'b0;
        i_wr       = 1'b0;
        i_req      = '0;
        i_cache_en = 1'b1;
        for (int i = 0; i < 256; i++)
                shadow[i] = {16'hA5C3, 6'd0, 10'(i * 4)};

        //        name          wr    en    addr     data          ben      exp rdata   rd wr victim
        add_entry("rd_miss",    1'b0, 1'b1, 32'h044, 32'h0,        4'hf,    32'hA5C3_0044, 4, 0, 32'h0);
        add_entry("rd_hit",     1'b0, 1'b1, 32'h044, 32'h0,        4'hf,    32'hA5C3_0044, 0, 0, 32'h0);
        add_entry("wr_hit",     1'b1, 1'b1, 32'h048, 32'h1122_3344, 4'b0101, 32'h0,        0, 0, 32'h0);
        add_entry("rd_merged",  1'b0, 1'b1, 32'h048, 32'h0,        4'hf,    32'hA522_0044, 0, 0, 32'h0);
        add_entry("rd_evict",   1'b0, 1'b1, 32'h14C, 32'h0,        4'hf,    32'hA5C3_014C, 4, 4, 32'h040);
        add_entry("rd_refill",  1'b0, 1'b1, 32'h048, 32'h0,        4'hf,    32'hA522_0044, 4, 0, 32'h0);
        add_entry("unc_wr",     1'b1, 1'b0, 32'h200, 32'hDEAD_BEEF, 4'b0011, 32'h0,        0, 1, 32'h0);
        add_entry("unc_rd",     1'b0, 1'b0, 32'h200, 32'h0,        4'hf,    32'hA5C3_BEEF, 1, 0, 32'h0);
        add_entry("wr_miss",    1'b1, 1'b1, 32'h084, 32'h0BAD_F00D, 4'b1100, 32'h0,        4, 0, 32'h0);
        add_entry("rd_wr_miss", 1'b0, 1'b1, 32'h084, 32'h0,        4'hf,    32'h0BAD_0084, 0, 0, 32'h0);
        add_entry("rd_evict2",  1'b0, 1'b1, 32'h184, 32'h0,        4'hf,    32'hA5C3_0184, 4, 4, 32'h080);
        add_entry("rd_wb_data", 1'b0, 1'b1, 32'h084, 32'h0,        4'hf,    32'h0BAD_0084, 4, 0, 32'h0);

        repeat (2) @(negedge i_clk);
        i_reset = 1'b0;

        // Quiet bus and no ack while nothing is requested
        repeat (5)
        begin
                @(negedge i_clk);
                check_word("reset_idle", 32'h0, {29'd0, o_ack, wb.cyc, wb.stb});
                check_cti("reset_idle cti", dcache_pkg::CTI_EOB, wb.cti);
        end

        for (int n = 0; n < steps.size(); n++)
                run_entry(n);

        $display("=== PASS ===");
        $finish;
end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
src/dcache_pkg.sv
src/dcache_store.sv
src/wb_burst_master.sv
src/dcache_ctrl.sv
src/dcache_top.sv
testbench/wb_mem_model.sv
testbench/tb_dcache.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the data cache testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_dcache_sim

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache -f project.f -o "$BIN"
if [ $? -ne 0 ]; then
        echo "Verilator build failed"
        exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
        echo "Simulation exited with status $status"
fi

if grep -qx "=== PASS ===" "$LOG"; then
        exit 0
fi
echo "Pass message not found in $LOG"
exit 1
